/* logic/qpu_params.svh */
/*
 * QPU execution stage parameters
 * Word, register file, instruction field, event and timing queue sizes
 * shared by the execution stage packages and modules.
 */

`ifndef QPU_PARAMS_SVH
`define QPU_PARAMS_SVH

`define QPU_XLEN        16   // Classical data word
`define QPU_RF_NUM      16   // Classical registers, x0 reads zero
`define QPU_RFIDX_W     4
`define QPU_INSTR_W     32

// Instruction fields
`define QPU_OPC_W       4
`define QPU_OPC_MSB     31
`define QPU_OPC_LSB     28
`define QPU_RD_MSB      27
`define QPU_RD_LSB      24
`define QPU_RS1_MSB     23
`define QPU_RS1_LSB     20
`define QPU_RS2_MSB     19
`define QPU_RS2_LSB     16
`define QPU_IMM_MSB     15
`define QPU_IMM_LSB     0

`define QPU_TIME_W      16   // Timepoint and trigger clock
`define QPU_EVENT_NUM   4    // Event lines
`define QPU_EVENT_W     8    // Event data
`define QPU_QUBIT_NUM   8    // Measurement register bits
`define QPU_TIQ_DEPTH   4    // Timing queue entries, power of two

`endif

/* logic/qpu_isa_pkg.sv */
/*
 * QPU instruction set package
 * Opcode encoding of the 4-bit opcode field. Codes not listed here
 * are treated as NOP by the decoder.
 */

`include "qpu_params.svh"

package qpu_isa_pkg;

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  typedef enum logic [`QPU_OPC_W-1:0] {
    OP_NOP   = 4'h0,
    OP_ADD   = 4'h1,  // rd = rs1 + rs2
    OP_ADDI  = 4'h2,  // rd = rs1 + imm
    OP_LD    = 4'h3,  // rd = mem[rs1 + imm], returns on the long pipe
    // Timepoint += imm
    OP_QWAIT = 4'h4,
    // Push {timepoint, imm[3:0], rs1[7:0]} to the timing queue
    OP_QEVT  = 4'h5,
    OP_FMR   = 4'h6   // rd = measurement register, zero-extended
  } opcode_e;

endpackage

/* logic/qpu_exu_pkg.sv */
/*
 * QPU execution stage datapath types
 * Register index, data word, time and event fields.
 */

`include "qpu_params.svh"

package qpu_exu_pkg;

  typedef logic [`QPU_RFIDX_W-1:0]   rf_idx_t;
  typedef logic [`QPU_XLEN-1:0]      xlen_t;
  typedef logic [`QPU_TIME_W-1:0]    time_t;

  // One bit per event line
  typedef logic [`QPU_EVENT_NUM-1:0] evt_mask_t;
  typedef logic [`QPU_EVENT_W-1:0]   evt_data_t;

endpackage

/* logic/qpu_exu_decode.sv */
/*
 * QPU instruction decoder
 * Splits the instruction word into opcode, register indices and
 * immediate. Unknown opcodes decode to NOP.
 */

`timescale 1ns/100ps

`include "qpu_params.svh"

module qpu_exu_decode (
  input  logic [`QPU_INSTR_W-1:0] i_instr,
  output qpu_isa_pkg::opcode_e    o_opcode,
  output qpu_exu_pkg::rf_idx_t    o_rd,
  output qpu_exu_pkg::rf_idx_t    o_rs1,
  output qpu_exu_pkg::rf_idx_t    o_rs2,
  output qpu_exu_pkg::xlen_t      o_imm,
  output logic                    o_rdwen
);

  logic [`QPU_OPC_W-1:0] opc_raw;

  assign opc_raw = i_instr[`QPU_OPC_MSB:`QPU_OPC_LSB];
  assign o_rd    = i_instr[`QPU_RD_MSB:`QPU_RD_LSB];
  assign o_rs1   = i_instr[`QPU_RS1_MSB:`QPU_RS1_LSB];
  assign o_rs2   = i_instr[`QPU_RS2_MSB:`QPU_RS2_LSB];
  assign o_imm   = i_instr[`QPU_IMM_MSB:`QPU_IMM_LSB];

  always_comb begin
    case (opc_raw)
      qpu_isa_pkg::OP_ADD,
      qpu_isa_pkg::OP_ADDI,
      qpu_isa_pkg::OP_LD,
      qpu_isa_pkg::OP_QWAIT,
      qpu_isa_pkg::OP_QEVT,
      qpu_isa_pkg::OP_FMR: o_opcode = qpu_isa_pkg::opcode_e'(opc_raw);
      default:             o_opcode = qpu_isa_pkg::OP_NOP;
    endcase
  end

  // Register write only for result producing ops, never to x0
  always_comb begin
    case (o_opcode)
      qpu_isa_pkg::OP_ADD,
      qpu_isa_pkg::OP_ADDI,
      qpu_isa_pkg::OP_LD,
      qpu_isa_pkg::OP_FMR: o_rdwen = (o_rd != '0);
      default:             o_rdwen = 1'b0;
    endcase
  end

endmodule

/* logic/qpu_exu_regfile.sv */
/*
 * QPU classical register file
 * Sixteen registers with one write port and two combinational read
 * ports, x0 hardwired to zero. Also holds the measurement register
 * loaded by the measurement controller.
 */

`timescale 1ns/100ps

`include "qpu_params.svh"

module qpu_exu_regfile (
  input  logic                       clk,
  input  logic                       i_reset,
  input  qpu_exu_pkg::rf_idx_t       i_rs1,
  input  qpu_exu_pkg::rf_idx_t       i_rs2,
  input  logic                       i_wen,
  input  qpu_exu_pkg::rf_idx_t       i_widx,
  input  qpu_exu_pkg::xlen_t         i_wdata,
  input  logic                       i_mcu_wen,
  input  logic [`QPU_QUBIT_NUM-1:0]  i_mcu_meas,
  output qpu_exu_pkg::xlen_t         o_rs1_data,
  output qpu_exu_pkg::xlen_t         o_rs2_data,
  output logic [`QPU_QUBIT_NUM-1:0]  o_meas
);

  qpu_exu_pkg::xlen_t         rf_q [`QPU_RF_NUM];
  logic [`QPU_QUBIT_NUM-1:0]  meas_q;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < `QPU_RF_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wen && (i_widx != '0)) begin  // Writes to x0 dropped
      rf_q[i_widx] <= i_wdata;
    end
  end

  // Measurement register
  always_ff @(posedge clk) begin
    if (i_reset) begin
      meas_q <= '0;
    end else if (i_mcu_wen) begin
      meas_q <= i_mcu_meas;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : rf_q[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : rf_q[i_rs2];
  assign o_meas     = meas_q;

endmodule

/* logic/qpu_exu_alu.sv */
/*
 * QPU execution unit
 * Executes one decoded instruction per strobe. Holds the timepoint
 * register and registers the write-back request, the load request and
 * the timing queue push for exactly one cycle.
 */

`timescale 1ns/100ps

`include "qpu_params.svh"

module qpu_exu_alu (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_valid,
  input  qpu_isa_pkg::opcode_e       i_opcode,
  input  qpu_exu_pkg::rf_idx_t       i_rd,
  input  logic                       i_rdwen,
  input  qpu_exu_pkg::xlen_t         i_imm,
  input  qpu_exu_pkg::xlen_t         i_rs1_data,
  input  qpu_exu_pkg::xlen_t         i_rs2_data,
  input  logic [`QPU_QUBIT_NUM-1:0]  i_meas,
  input  logic                       i_tiq_full,
  output logic                       o_wb_valid,
  output qpu_exu_pkg::rf_idx_t       o_wb_idx,
  output qpu_exu_pkg::xlen_t         o_wb_data,
  output logic                       o_lsu_req,
  output qpu_exu_pkg::xlen_t         o_lsu_addr,
  output qpu_exu_pkg::rf_idx_t       o_ld_rd,
  output logic                       o_tiq_push,
  output qpu_exu_pkg::time_t         o_tiq_time,
  output qpu_exu_pkg::evt_mask_t     o_tiq_mask,
  output qpu_exu_pkg::evt_data_t     o_tiq_data
);

  qpu_exu_pkg::time_t  time_q;    // Current timepoint
  qpu_exu_pkg::xlen_t  imm_sum;   // Shared by ADDI and LD address
  qpu_exu_pkg::xlen_t  wb_res;
  logic                wb_en;
  logic                ld_en;
  logic                push_en;
  logic                wait_en;

  assign imm_sum = i_rs1_data + i_imm;

  //////////////////////////////
  // Execute
  //////////////////////////////
  always_comb begin
    wb_en   = 1'b0;
    ld_en   = 1'b0;
    push_en = 1'b0;
    wait_en = 1'b0;
    wb_res  = imm_sum;
    if (i_valid) begin
      case (i_opcode)
        qpu_isa_pkg::OP_ADD: begin
          wb_en  = i_rdwen;
          wb_res = i_rs1_data + i_rs2_data;
        end
        qpu_isa_pkg::OP_ADDI: wb_en = i_rdwen;
        qpu_isa_pkg::OP_FMR: begin
          wb_en  = i_rdwen;
          wb_res = {{(`QPU_XLEN-`QPU_QUBIT_NUM){1'b0}}, i_meas};
        end
        qpu_isa_pkg::OP_LD:    ld_en   = 1'b1;
        qpu_isa_pkg::OP_QWAIT: wait_en = 1'b1;
        qpu_isa_pkg::OP_QEVT:  push_en = ~i_tiq_full;  // Dropped when full
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_wb_valid <= 1'b0;
      o_lsu_req  <= 1'b0;
      o_tiq_push <= 1'b0;
      time_q     <= '0;
    end else begin
      o_wb_valid <= wb_en;
      o_lsu_req  <= ld_en;
      o_tiq_push <= push_en;
      if (wait_en) time_q <= time_q + i_imm;
    end
  end

  // Payload, only meaningful with its strobe
  always_ff @(posedge clk) begin
    if (wb_en) begin
      o_wb_idx  <= i_rd;
      o_wb_data <= wb_res;
    end
    if (ld_en) begin
      o_lsu_addr <= imm_sum;
      o_ld_rd    <= i_rd;
    end
    if (push_en) begin
      o_tiq_time <= time_q;
      o_tiq_mask <= i_imm[`QPU_EVENT_NUM-1:0];
      o_tiq_data <= i_rs1_data[`QPU_EVENT_W-1:0];
    end
  end

endmodule

/* logic/qpu_exu_longpwbck.sv */
/*
 * QPU long-pipe write-back
 * Tracks the single outstanding load, buffers the returned data and
 * requests the register file write port until it is granted.
 */

`timescale 1ns/100ps

module qpu_exu_longpwbck (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_ld_req,
  input  qpu_exu_pkg::rf_idx_t  i_ld_rd,
  input  logic                  i_lsu_valid,
  input  qpu_exu_pkg::xlen_t    i_lsu_data,
  input  logic                  i_grant,
  output logic                  o_req,
  output qpu_exu_pkg::rf_idx_t  o_idx,
  output qpu_exu_pkg::xlen_t    o_data,
  output logic                  o_busy
);

  logic                  pend_q;   // Load outstanding
  logic                  full_q;   // Return data waiting for the port
  logic                  capture;
  qpu_exu_pkg::rf_idx_t  idx_q;
  qpu_exu_pkg::xlen_t    data_q;

  assign o_busy  = pend_q | i_ld_req;  // Busy from the request cycle on
  assign capture = i_lsu_valid & o_busy & ~full_q;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pend_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      if (i_ld_req) pend_q <= 1'b1;
      else if (full_q && i_grant) pend_q <= 1'b0;
      if (capture) full_q <= 1'b1;
      else if (i_grant) full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_ld_req) idx_q <= i_ld_rd;
    if (capture) data_q <= i_lsu_data;
  end

  assign o_req  = full_q;
  assign o_idx  = idx_q;
  assign o_data = data_q;

endmodule

/* logic/qpu_exu_wbck.sv */
/*
 * QPU write-back arbiter
 * Fixed priority on the register file write port. The execution
 * unit always wins, the long pipe waits in its own buffer.
 */

`timescale 1ns/100ps

module qpu_exu_wbck (
  input  logic                  i_alu_valid,
  input  qpu_exu_pkg::rf_idx_t  i_alu_idx,
  input  qpu_exu_pkg::xlen_t    i_alu_data,
  input  logic                  i_longp_req,
  input  qpu_exu_pkg::rf_idx_t  i_longp_idx,
  input  qpu_exu_pkg::xlen_t    i_longp_data,
  output logic                  o_longp_grant,
  output logic                  o_wen,
  output qpu_exu_pkg::rf_idx_t  o_widx,
  output qpu_exu_pkg::xlen_t    o_wdata
);

  assign o_longp_grant = i_longp_req & ~i_alu_valid;

  assign o_wen   = i_alu_valid | i_longp_req;
  assign o_widx  = i_alu_valid ? i_alu_idx  : i_longp_idx;
  assign o_wdata = i_alu_valid ? i_alu_data : i_longp_data;

endmodule

/* logic/qpu_exu_timing_queue.sv */
/*
 * QPU timing queue
 * Circular FIFO of timed events. The head event is released for one
 * cycle once the trigger clock reaches its timepoint, only while the
 * trigger is enabled. Events leave in push order.
 */

`timescale 1ns/100ps

`include "qpu_params.svh"

module qpu_exu_timing_queue #(
  parameter int DEPTH = `QPU_TIQ_DEPTH  // Power of two
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_push,
  input  qpu_exu_pkg::time_t      i_time,
  input  qpu_exu_pkg::evt_mask_t  i_mask,
  input  qpu_exu_pkg::evt_data_t  i_data,
  input  logic                    i_trigger,
  input  qpu_exu_pkg::time_t      i_trig_clk,
  output logic                    o_full,
  output logic                    o_empty,
  output qpu_exu_pkg::evt_mask_t  o_evt_valid,
  output qpu_exu_pkg::evt_data_t  o_evt_data
);

  localparam int PTR_W = $clog2(DEPTH);

  qpu_exu_pkg::time_t      time_mem [DEPTH];
  qpu_exu_pkg::evt_mask_t  mask_mem [DEPTH];
  qpu_exu_pkg::evt_data_t  data_mem [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;   // Wraps naturally
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              do_push;
  logic              do_pop;

  assign o_full  = (count == DEPTH);
  assign o_empty = (count == '0);

  assign do_push = i_push & ~o_full;
  assign do_pop  = ~o_empty & i_trigger & (i_trig_clk >= time_mem[rd_ptr]);

  //////////////////////////////
  // Pointers and count
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      time_mem[wr_ptr] <= i_time;
      mask_mem[wr_ptr] <= i_mask;
      data_mem[wr_ptr] <= i_data;
    end
  end

  //////////////////////////////
  // Event output, one cycle per release
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_evt_valid <= '0;
    end else begin
      o_evt_valid <= do_pop ? mask_mem[rd_ptr] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (do_pop) o_evt_data <= data_mem[rd_ptr];
  end

endmodule

/* logic/qpu_exu.sv */
/*
 * QPU execution stage
 * Decode, classical register file, execution unit, long-pipe
 * write-back, write-back arbiter and timing queue.
 */

`timescale 1ns/100ps

`include "qpu_params.svh"

module qpu_exu (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_valid,     // Instruction strobe
  input  logic [`QPU_INSTR_W-1:0]    i_instr,
  output logic                       o_lsu_req,   // Load request
  output qpu_exu_pkg::xlen_t         o_lsu_addr,
  input  logic                       i_lsu_valid, // Load return
  input  qpu_exu_pkg::xlen_t         i_lsu_data,
  input  logic                       i_mcu_wen,
  input  logic [`QPU_QUBIT_NUM-1:0]  i_mcu_meas,
  input  logic                       i_trigger,
  input  qpu_exu_pkg::time_t         i_trig_clk,
  output qpu_exu_pkg::evt_mask_t     o_evt_valid,
  output qpu_exu_pkg::evt_data_t     o_evt_data,
  output logic                       o_busy,
  output logic                       o_active
);

  qpu_isa_pkg::opcode_e       dec_opcode;
  qpu_exu_pkg::rf_idx_t       dec_rd, dec_rs1, dec_rs2;
  qpu_exu_pkg::xlen_t         dec_imm;
  logic                       dec_rdwen;
  qpu_exu_pkg::xlen_t         rs1_data, rs2_data;
  logic [`QPU_QUBIT_NUM-1:0]  meas;
  logic                       rf_wen;
  qpu_exu_pkg::rf_idx_t       rf_widx;
  qpu_exu_pkg::xlen_t         rf_wdata;
  logic                       alu_wb_valid;
  qpu_exu_pkg::rf_idx_t       alu_wb_idx, alu_ld_rd;
  qpu_exu_pkg::xlen_t         alu_wb_data;
  logic                       longp_req, longp_grant;
  qpu_exu_pkg::rf_idx_t       longp_idx;
  qpu_exu_pkg::xlen_t         longp_data;
  logic                       tiq_push, tiq_full, tiq_empty;
  qpu_exu_pkg::time_t         tiq_time;
  qpu_exu_pkg::evt_mask_t     tiq_mask;
  qpu_exu_pkg::evt_data_t     tiq_data;

  //////////////////////////////
  // Issue
  //////////////////////////////
  qpu_exu_decode u_qpu_exu_decode (
    .i_instr  (i_instr   ),
    .o_opcode (dec_opcode),
    .o_rd     (dec_rd    ),
    .o_rs1    (dec_rs1   ),
    .o_rs2    (dec_rs2   ),
    .o_imm    (dec_imm   ),
    .o_rdwen  (dec_rdwen )
  );

  qpu_exu_regfile u_qpu_exu_regfile (
    .clk        (clk       ),
    .i_reset    (i_reset   ),
    .i_rs1      (dec_rs1   ),
    .i_rs2      (dec_rs2   ),
    .i_wen      (rf_wen    ),
    .i_widx     (rf_widx   ),
    .i_wdata    (rf_wdata  ),
    .i_mcu_wen  (i_mcu_wen ),
    .i_mcu_meas (i_mcu_meas),
    .o_rs1_data (rs1_data  ),
    .o_rs2_data (rs2_data  ),
    .o_meas     (meas      )
  );

  qpu_exu_alu u_qpu_exu_alu (
    .clk        (clk         ),
    .i_reset    (i_reset     ),
    .i_valid    (i_valid     ),
    .i_opcode   (dec_opcode  ),
    .i_rd       (dec_rd      ),
    .i_rdwen    (dec_rdwen   ),
    .i_imm      (dec_imm     ),
    .i_rs1_data (rs1_data    ),
    .i_rs2_data (rs2_data    ),
    .i_meas     (meas        ),
    .i_tiq_full (tiq_full    ),
    .o_wb_valid (alu_wb_valid),
    .o_wb_idx   (alu_wb_idx  ),
    .o_wb_data  (alu_wb_data ),
    .o_lsu_req  (o_lsu_req   ),
    .o_lsu_addr (o_lsu_addr  ),
    .o_ld_rd    (alu_ld_rd   ),
    .o_tiq_push (tiq_push    ),
    .o_tiq_time (tiq_time    ),
    .o_tiq_mask (tiq_mask    ),
    .o_tiq_data (tiq_data    )
  );

  //////////////////////////////
  // Write-back
  //////////////////////////////
  qpu_exu_longpwbck u_qpu_exu_longpwbck (
    .clk         (clk        ),
    .i_reset     (i_reset    ),
    .i_ld_req    (o_lsu_req  ),
    .i_ld_rd     (alu_ld_rd  ),
    .i_lsu_valid (i_lsu_valid),
    .i_lsu_data  (i_lsu_data ),
    .i_grant     (longp_grant),
    .o_req       (longp_req  ),
    .o_idx       (longp_idx  ),
    .o_data      (longp_data ),
    .o_busy      (o_busy     )
  );

  qpu_exu_wbck u_qpu_exu_wbck (
    .i_alu_valid   (alu_wb_valid),
    .i_alu_idx     (alu_wb_idx  ),
    .i_alu_data    (alu_wb_data ),
    .i_longp_req   (longp_req   ),
    .i_longp_idx   (longp_idx   ),
    .i_longp_data  (longp_data  ),
    .o_longp_grant (longp_grant ),
    .o_wen         (rf_wen      ),
    .o_widx        (rf_widx     ),
    .o_wdata       (rf_wdata    )
  );

  qpu_exu_timing_queue #(
    .DEPTH (`QPU_TIQ_DEPTH)
  ) u_qpu_exu_timing_queue (
    .clk         (clk        ),
    .i_reset     (i_reset    ),
    .i_push      (tiq_push   ),
    .i_time      (tiq_time   ),
    .i_mask      (tiq_mask   ),
    .i_data      (tiq_data   ),
    .i_trigger   (i_trigger  ),
    .i_trig_clk  (i_trig_clk ),
    .o_full      (tiq_full   ),
    .o_empty     (tiq_empty  ),
    .o_evt_valid (o_evt_valid),
    .o_evt_data  (o_evt_data )
  );

  // Work in flight anywhere in the stage
  assign o_active = o_busy | ~tiq_empty | i_valid;

endmodule

/* dv/qpu_exu_assert.sv */
/*
 * QPU execution stage assertions
 * Load request, busy and event output rules, bound to the top level.
 */

`timescale 1ns/100ps

`include "qpu_params.svh"

module qpu_exu_assert (
  input logic                       clk,
  input logic                       i_reset,
  input logic                       i_lsu_req,
  input logic                       i_lsu_valid,
  input logic                       i_busy,
  input logic [`QPU_EVENT_NUM-1:0]  i_evt_valid
);

  logic ret_seen;  // Load data returned since the last request

  always_ff @(posedge clk) begin
    if (i_reset) begin
      ret_seen <= 1'b0;
    end else if (i_lsu_valid && i_busy) begin
      ret_seen <= 1'b1;
    end else if (i_lsu_req) begin
      ret_seen <= 1'b0;
    end
  end

  // New load only from idle
  a_req_idle: assert property (@(posedge clk) disable iff (i_reset)
    $rose(i_lsu_req) |-> !$past(i_busy))
    else $error("load request raised while a load was pending");

  a_evt_reset: assert property (@(posedge clk) $past(i_reset) |-> (i_evt_valid == '0))
    else $error("event output not cleared by reset");

  a_busy_fall: assert property (@(posedge clk) disable iff (i_reset)
    $fell(i_busy) |-> ret_seen)
    else $error("busy dropped before load data returned");

endmodule

bind qpu_exu qpu_exu_assert u_qpu_exu_assert (
  .clk         (clk        ),
  .i_reset     (i_reset    ),
  .i_lsu_req   (o_lsu_req  ),
  .i_lsu_valid (i_lsu_valid),
  .i_busy      (o_busy     ),
  .i_evt_valid (o_evt_valid)
);

/* dv/qpu_exu_tb.sv */
/*
 * QPU execution stage testbench
 * Directed tests for ALU write-back, loads and their return, write-back
 * arbitration, timed events and the measurement register.
 */

`timescale 1ns/100ps

`include "qpu_params.svh"

module qpu_exu_tb;

  logic                       clk = 1'b0;
  logic                       i_reset;
  logic                       i_valid;
  logic [`QPU_INSTR_W-1:0]    i_instr;
  logic                       o_lsu_req;
  logic [`QPU_XLEN-1:0]       o_lsu_addr;
  logic                       i_lsu_valid;
  logic [`QPU_XLEN-1:0]       i_lsu_data;
  logic                       i_mcu_wen;
  logic [`QPU_QUBIT_NUM-1:0]  i_mcu_meas;
  logic                       i_trigger;
  logic [`QPU_TIME_W-1:0]     i_trig_clk;
  logic [`QPU_EVENT_NUM-1:0]  o_evt_valid;
  logic [`QPU_EVENT_W-1:0]    o_evt_data;
  logic                       o_busy;
  logic                       o_active;

  logic [`QPU_XLEN-1:0]       regs [`QPU_RF_NUM];  // Register file model
  logic [`QPU_TIME_W-1:0]     tp;                  // Timepoint model
  logic [`QPU_RFIDX_W-1:0]    pend_rd;
  logic [31:0]                lcg_state = 32'd67;
  logic [`QPU_TIME_W-1:0]     q_time [$];          // Timing queue model
  logic [`QPU_EVENT_NUM-1:0]  q_mask [$];
  logic [`QPU_EVENT_W-1:0]    q_data [$];

  qpu_exu dut0 (.*);

  always #4 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic logic [31:0] encode(input qpu_isa_pkg::opcode_e op, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2,
                                         input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;  // Drive just after the edge
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // One instruction followed by one idle cycle
  task automatic issue(input logic [31:0] instr);
    i_valid = 1'b1;
    i_instr = instr;
    tick();
    i_valid = 1'b0;
    i_instr = '0;
    tick();
  endtask

  task automatic addi(input logic [3:0] rd, input logic [3:0] rs1, input logic [15:0] imm);
    issue(encode(qpu_isa_pkg::OP_ADDI, rd, rs1, 4'd0, imm));
    if (rd != 0) regs[rd] = regs[rs1] + imm;
  endtask

  task automatic add_rr(input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2);
    issue(encode(qpu_isa_pkg::OP_ADD, rd, rs1, rs2, 16'd0));
    if (rd != 0) regs[rd] = regs[rs1] + regs[rs2];
  endtask

  task automatic qwait(input logic [15:0] dt);
    issue(encode(qpu_isa_pkg::OP_QWAIT, 4'd0, 4'd0, 4'd0, dt));
    tp = tp + dt;
  endtask

  task automatic qevt(input logic [3:0] rs1, input logic [3:0] mask);
    issue(encode(qpu_isa_pkg::OP_QEVT, 4'd0, rs1, 4'd0, {12'd0, mask}));
    if (q_time.size() < `QPU_TIQ_DEPTH) begin  // Full queue drops the push
      q_time.push_back(tp);
      q_mask.push_back(mask);
      q_data.push_back(regs[rs1][7:0]);
    end
  endtask

  // Request and address show up exactly one cycle after issue
  task automatic start_load(input logic [3:0] rd, input logic [3:0] rs1, input logic [15:0] imm);
    logic [15:0] addr;
    addr = regs[rs1] + imm;
    i_valid = 1'b1;
    i_instr = encode(qpu_isa_pkg::OP_LD, rd, rs1, 4'd0, imm);
    tick();
    i_valid = 1'b0;
    i_instr = '0;
    check("o_lsu_req", 1, o_lsu_req);
    check("o_busy", 1, o_busy);
    check("o_lsu_addr", addr, o_lsu_addr);
    pend_rd = rd;
    tick();
    check("o_lsu_req", 0, o_lsu_req);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (o_busy && n < 20) begin
      tick();
      n++;
    end
    if (o_busy) begin
      $display("load write-back did not finish, o_busy still high after 20 cycles");
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout on o_busy");
    end
  endtask

  task automatic finish_load(input logic [15:0] data);
    i_lsu_valid = 1'b1;
    i_lsu_data  = data;
    tick();
    i_lsu_valid = 1'b0;
    wait_idle();
    if (pend_rd != 0) regs[pend_rd] = data;
  endtask

  // Register value exposed as a load address
  task automatic read_reg(input logic [3:0] idx);
    start_load(4'd0, idx, 16'd0);
    finish_load(next_rand());
  endtask

  // One trigger clock cycle checked against the queue model
  task automatic step_trig(input logic [15:0] t);
    logic fire;
    fire = 1'b0;
    if (i_trigger && q_time.size() > 0) fire = (t >= q_time[0]);
    i_trig_clk = t;
    tick();
    if (fire) begin
      check("o_evt_valid", q_mask[0], o_evt_valid);
      check("o_evt_data", q_data[0], o_evt_data);
      void'(q_time.pop_front());
      void'(q_mask.pop_front());
      void'(q_data.pop_front());
    end else begin
      check("o_evt_valid", 0, o_evt_valid);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic reset_values();
    check("o_lsu_req", 0, o_lsu_req);
    check("o_busy", 0, o_busy);
    check("o_evt_valid", 0, o_evt_valid);
    check("o_active", 0, o_active);
  endtask

  task automatic alu_ops();
    for (int r = 1; r <= 6; r++) addi(r[3:0], 4'd0, next_rand());
    add_rr(4'd7, 4'd1, 4'd2);
    add_rr(4'd8, 4'd7, 4'd3);
    addi(4'd9, 4'd8, next_rand());
    add_rr(4'd5, 4'd5, 4'd6);
    for (int r = 1; r <= 9; r++) read_reg(r[3:0]);
  endtask

  task automatic load_return();
    start_load(4'd10, 4'd1, next_rand());
    finish_load(next_rand());
    start_load(4'd0, 4'd10, next_rand());  // Returned data plus imm
    finish_load(next_rand());
  endtask

  // Load data arrives while the ALU holds the write port
  task automatic wb_conflict();
    logic [15:0] ld_data;
    logic [15:0] imm;
    ld_data = next_rand();
    imm = next_rand();
    start_load(4'd11, 4'd2, next_rand());
    i_valid     = 1'b1;
    i_instr     = encode(qpu_isa_pkg::OP_ADDI, 4'd12, 4'd3, 4'd0, imm);
    i_lsu_valid = 1'b1;
    i_lsu_data  = ld_data;
    tick();
    i_valid     = 1'b0;
    i_lsu_valid = 1'b0;
    check("o_busy", 1, o_busy);
    regs[12] = regs[3] + imm;
    wait_idle();
    regs[11] = ld_data;
    read_reg(4'd11);
    read_reg(4'd12);
  endtask

  task automatic timed_events();
    logic [15:0] t_max;
    i_trigger = 1'b0;
    for (int k = 0; k < 3; k++) begin
      qwait(16'd10 + (next_rand() & 16'h7));
      addi(4'd13, 4'd0, next_rand());
      qevt(4'd13, 4'(next_rand() % 15 + 1));
    end
    check("o_active", 1, o_active);
    t_max = tp + 16'd4;
    for (int k = 0; k < 4; k++) step_trig(t_max);  // Trigger off so nothing leaves
    i_trigger = 1'b1;
    for (int t = 0; t <= t_max; t++) step_trig(t[15:0]);
    check("o_active", q_time.size() != 0, o_active);  // Queue drained
  endtask

  task automatic measurement_event();
    logic [7:0] meas;
    meas = 8'(next_rand());
    i_trigger  = 1'b0;
    i_mcu_wen  = 1'b1;
    i_mcu_meas = meas;
    tick();
    i_mcu_wen  = 1'b0;
    issue(encode(qpu_isa_pkg::OP_FMR, 4'd14, 4'd0, 4'd0, 16'd0));
    regs[14] = {8'h00, meas};
    read_reg(4'd14);
    qevt(4'd14, 4'h9);
    i_trigger = 1'b1;
    step_trig(tp);
    check("o_active", q_time.size() != 0, o_active);
  endtask

  initial begin
    i_reset     = 1'b1;
    i_valid     = 1'b0;
    i_instr     = '0;
    i_lsu_valid = 1'b0;
    i_lsu_data  = '0;
    i_mcu_wen   = 1'b0;
    i_mcu_meas  = '0;
    i_trigger   = 1'b0;
    i_trig_clk  = '0;
    pend_rd     = '0;
    tp          = '0;
    for (int r = 0; r < `QPU_RF_NUM; r++) regs[r] = '0;
    repeat (10) tick();
    i_reset = 1'b0;
    tick();

    reset_values();
    alu_ops();
    load_return();
    wb_conflict();
    timed_events();
    measurement_event();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* build.f */
+incdir+logic
logic/qpu_isa_pkg.sv
logic/qpu_exu_pkg.sv
logic/qpu_exu_decode.sv
logic/qpu_exu_regfile.sv
logic/qpu_exu_alu.sv
logic/qpu_exu_longpwbck.sv
logic/qpu_exu_wbck.sv
logic/qpu_exu_timing_queue.sv
logic/qpu_exu.sv
dv/qpu_exu_assert.sv
dv/qpu_exu_tb.sv

/* Bender.yml */
package:
  name: qpu_exu

sources:
  - include_dirs:
      - logic
    files:
      - logic/qpu_isa_pkg.sv
      - logic/qpu_exu_pkg.sv
      - logic/qpu_exu_decode.sv
      - logic/qpu_exu_regfile.sv
      - logic/qpu_exu_alu.sv
      - logic/qpu_exu_longpwbck.sv
      - logic/qpu_exu_wbck.sv
      - logic/qpu_exu_timing_queue.sv
      - logic/qpu_exu.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/qpu_exu_assert.sv
      - dv/qpu_exu_tb.sv
